// File: byte_pack.f
+incdir+logic
logic/axis_pkg.sv
logic/pack_pkg.sv
logic/pack_shift_unit.sv
logic/pack_compactor.sv
logic/pack_keep_decode.sv
logic/pack_output_stage.sv
logic/byte_pack.sv
verif/tb_clock_gen.sv
verif/tb_byte_pack.sv

// File: logic/axis_pkg.sv
// stream field types
`default_nettype none

`include "pack_defs.svh"

package axis_pkg;

    typedef logic [7:0] axis_byte_t;                            // one lane

    // tdata seen lane by lane
    typedef axis_byte_t [`PACK_TDATA_BYTES-1:0] axis_data_t;

    typedef logic [`PACK_TDATA_BYTES-1:0] axis_keep_t;          // one bit per lane

    typedef logic [`PACK_TDEST_WIDTH-1:0] axis_dest_t;          // passed through as is

endpackage

`default_nettype wire

// File: logic/byte_pack.sv
// stream byte packer top
`default_nettype none

module byte_pack (
    input  logic                  aclk,
    input  logic                  rst,
    // input stream with sparse keep
    input  logic                  rx_tvalid,
    output logic                  rx_tready,
    input  axis_pkg::axis_data_t  rx_tdata,
    input  axis_pkg::axis_keep_t  rx_tkeep,
    input  logic                  rx_tlast,
    input  axis_pkg::axis_dest_t  rx_tdest,
    // output stream packed low
    output logic                  tx_tvalid,
    input  logic                  tx_tready,
    output axis_pkg::axis_data_t  tx_tdata,
    output axis_pkg::axis_keep_t  tx_tkeep,
    output logic                  tx_tlast,
    output axis_pkg::axis_dest_t  tx_tdest,
    output pack_pkg::pack_count_t tx_tcount
);
    import axis_pkg::*;
    import pack_pkg::*;

    // decode register to output register
    logic        dec_valid;
    logic        dec_ready;
    axis_data_t  dec_tdata;
    axis_keep_t  dec_tkeep;
    logic        dec_tlast;
    axis_dest_t  dec_tdest;
    pack_count_t dec_count;

    axis_data_t  cmp_tdata;     // compactor result
    axis_keep_t  cmp_tkeep;

    pack_keep_decode i_decode (
        .aclk      (aclk),
        .rst       (rst),
        .rx_tvalid (rx_tvalid),
        .rx_tready (rx_tready),
        .rx_tdata  (rx_tdata),
        .rx_tkeep  (rx_tkeep),
        .rx_tlast  (rx_tlast),
        .rx_tdest  (rx_tdest),
        .dec_valid (dec_valid),
        .dec_ready (dec_ready),
        .dec_tdata (dec_tdata),
        .dec_tkeep (dec_tkeep),
        .dec_tlast (dec_tlast),
        .dec_tdest (dec_tdest),
        .dec_count (dec_count)
    );

    // combinational between the two registers, valid bypasses it
    pack_compactor i_compactor (
        .in_tdata  (dec_tdata),
        .in_tkeep  (dec_tkeep),
        .out_tdata (cmp_tdata),
        .out_tkeep (cmp_tkeep)
    );

    pack_output_stage i_output (
        .aclk      (aclk),
        .rst       (rst),
        .in_valid  (dec_valid),
        .in_ready  (dec_ready),
        .in_tdata  (cmp_tdata),
        .in_tkeep  (cmp_tkeep),
        .in_tlast  (dec_tlast),
        .in_tdest  (dec_tdest),
        .in_count  (dec_count),
        .tx_tvalid (tx_tvalid),
        .tx_tready (tx_tready),
        .tx_tdata  (tx_tdata),
        .tx_tkeep  (tx_tkeep),
        .tx_tlast  (tx_tlast),
        .tx_tdest  (tx_tdest),
        .tx_tcount (tx_tcount)
    );

endmodule

`default_nettype wire

// File: logic/pack_compactor.sv
// full beat compaction chain
`default_nettype none

`include "pack_defs.svh"

module pack_compactor (
    input  axis_pkg::axis_data_t in_tdata,
    input  axis_pkg::axis_keep_t in_tkeep,
    output axis_pkg::axis_data_t out_tdata,
    output axis_pkg::axis_keep_t out_tkeep
);
    import axis_pkg::*;

    // at most lanes-1 holes sit under the top kept byte
    localparam int STAGES = `PACK_TDATA_BYTES - 1;

    axis_data_t stage_tdata [STAGES+1];
    axis_keep_t stage_tkeep [STAGES+1];

    // clear unkept lanes first so only zeros move around them
    always_comb begin
        for (int k = 0; k < `PACK_TDATA_BYTES; k++) begin
            stage_tdata[0][k] = in_tkeep[k] ? in_tdata[k] : axis_byte_t'(8'h00);
        end
    end

    assign stage_tkeep[0] = in_tkeep;

    for (genvar s = 0; s < STAGES; s++) begin : g_stage
        pack_shift_unit i_shift (
            .in_tdata  (stage_tdata[s]),
            .in_tkeep  (stage_tkeep[s]),
            .out_tdata (stage_tdata[s+1]),
            .out_tkeep (stage_tkeep[s+1])
        );
    end

    assign out_tdata = stage_tdata[STAGES];     // packed low
    assign out_tkeep = stage_tkeep[STAGES];     // contiguous from lane 0

endmodule

`default_nettype wire

// File: logic/pack_defs.svh
// byte packer sizes
`ifndef PACK_DEFS_SVH
`define PACK_DEFS_SVH

// byte lanes on tdata
`define PACK_TDATA_BYTES 4

// width of the routing tag
`define PACK_TDEST_WIDTH 2

`endif

// File: logic/pack_keep_decode.sv
// input stage with null beat drop
`default_nettype none

module pack_keep_decode (
    input  logic                  aclk,
    input  logic                  rst,
    // upstream stream
    input  logic                  rx_tvalid,
    output logic                  rx_tready,
    input  axis_pkg::axis_data_t  rx_tdata,
    input  axis_pkg::axis_keep_t  rx_tkeep,
    input  logic                  rx_tlast,
    input  axis_pkg::axis_dest_t  rx_tdest,
    // towards the compactor and output stage
    output logic                  dec_valid,
    input  logic                  dec_ready,
    output axis_pkg::axis_data_t  dec_tdata,
    output axis_pkg::axis_keep_t  dec_tkeep,
    output logic                  dec_tlast,
    output axis_pkg::axis_dest_t  dec_tdest,
    output pack_pkg::pack_count_t dec_count
);
    import pack_pkg::*;

    logic rx_fire;      // beat transfers this edge
    logic rx_null;      // nothing kept and no tlast
    logic load;         // beat actually enters the register

    // empty stage or downstream draining it
    assign rx_tready = !dec_valid || dec_ready;
    assign rx_fire   = rx_tvalid && rx_tready;

    // an empty keep still matters when it closes a packet
    assign rx_null = !(|rx_tkeep) && !rx_tlast;
    assign load    = rx_fire && !rx_null;

    always_ff @(posedge aclk) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else if (load) begin
            dec_valid <= 1'b1;
        end else if (dec_ready) begin
            dec_valid <= 1'b0;      // held beat left, nothing new
        end
    end

    always_ff @(posedge aclk) begin
        if (load) begin
            dec_tdata <= rx_tdata;
            dec_tkeep <= rx_tkeep;
            dec_tlast <= rx_tlast;
            dec_tdest <= rx_tdest;
            dec_count <= count_kept(rx_tkeep);  // byte count for the output side
        end
    end

endmodule

`default_nettype wire

// File: logic/pack_output_stage.sv
// output result register
`default_nettype none

module pack_output_stage (
    input  logic                  aclk,
    input  logic                  rst,
    // compacted beat from decode and compactor
    input  logic                  in_valid,
    output logic                  in_ready,
    input  axis_pkg::axis_data_t  in_tdata,
    input  axis_pkg::axis_keep_t  in_tkeep,
    input  logic                  in_tlast,
    input  axis_pkg::axis_dest_t  in_tdest,
    input  pack_pkg::pack_count_t in_count,
    // downstream stream
    output logic                  tx_tvalid,
    input  logic                  tx_tready,
    output axis_pkg::axis_data_t  tx_tdata,
    output axis_pkg::axis_keep_t  tx_tkeep,
    output logic                  tx_tlast,
    output axis_pkg::axis_dest_t  tx_tdest,
    output pack_pkg::pack_count_t tx_tcount
);
    logic in_fire;

    // room when empty or when the sink takes the current beat
    assign in_ready = !tx_tvalid || tx_tready;
    assign in_fire  = in_valid && in_ready;

    always_ff @(posedge aclk) begin
        if (rst) begin
            tx_tvalid <= 1'b0;
        end else if (in_ready) begin
            tx_tvalid <= in_valid;      // refill or go empty
        end
    end

    // fields frozen while stalled
    always_ff @(posedge aclk) begin
        if (in_fire) begin
            tx_tdata  <= in_tdata;
            tx_tkeep  <= in_tkeep;
            tx_tlast  <= in_tlast;
            tx_tdest  <= in_tdest;
            tx_tcount <= in_count;
        end
    end

endmodule

`default_nettype wire

// File: logic/pack_pkg.sv
// packer internal types
`default_nettype none

`include "pack_defs.svh"

package pack_pkg;

    // must hold 0 up to the full lane count
    localparam int PACK_COUNT_WIDTH = $clog2(`PACK_TDATA_BYTES + 1);

    typedef logic [PACK_COUNT_WIDTH-1:0] pack_count_t;

    // population count of a keep mask
    function automatic pack_count_t count_kept(input axis_pkg::axis_keep_t keep);
        pack_count_t total;
        total = '0;
        for (int k = 0; k < `PACK_TDATA_BYTES; k++) begin
            total += pack_count_t'(keep[k]);    // widen before adding
        end
        return total;
    endfunction

endpackage

`default_nettype wire

// File: logic/pack_shift_unit.sv
// single hole shift step
`default_nettype none

`include "pack_defs.svh"

module pack_shift_unit (
    input  axis_pkg::axis_data_t in_tdata,
    input  axis_pkg::axis_keep_t in_tkeep,
    output axis_pkg::axis_data_t out_tdata,
    output axis_pkg::axis_keep_t out_tkeep
);
    import axis_pkg::*;

    axis_byte_t [`PACK_TDATA_BYTES:0] data_ext;     // extra zero lane on top
    logic [`PACK_TDATA_BYTES:0]       keep_ext;
    axis_keep_t                       select;       // lane and all below kept

    assign data_ext = {axis_byte_t'(8'h00), in_tdata};
    assign keep_ext = {1'b0, in_tkeep};

    // running and of keep from lane 0 upwards
    always_comb begin
        select[0] = in_tkeep[0];
        for (int k = 1; k < `PACK_TDATA_BYTES; k++) begin
            select[k] = select[k-1] & in_tkeep[k];
        end
    end

    // below the first hole stay put, from the hole up pull one lane down
    always_comb begin
        for (int k = 0; k < `PACK_TDATA_BYTES; k++) begin
            out_tdata[k] = select[k] ? data_ext[k] : data_ext[k+1];
            out_tkeep[k] = select[k] ? keep_ext[k] : keep_ext[k+1];
        end
    end

endmodule

`default_nettype wire

// File: verif/tb_byte_pack.sv
// byte packer testbench
`default_nettype none

`include "pack_defs.svh"

module tb_byte_pack;
    import axis_pkg::*;
    import pack_pkg::*;

    localparam int ROWS            = 20;
    localparam int PASSES          = 2;     // pass 0 always ready, pass 1 throttled
    localparam int RESET_CYCLES    = 8;
    localparam int WATCHDOG_CYCLES = ROWS * PASSES * 16 + 100;

    logic        aclk;
    logic        rst;
    logic        rx_tvalid;
    logic        rx_tready;
    axis_data_t  rx_tdata;
    axis_keep_t  rx_tkeep;
    logic        rx_tlast;
    axis_dest_t  rx_tdest;
    logic        tx_tvalid;
    logic        tx_tready;
    axis_data_t  tx_tdata;
    axis_keep_t  tx_tkeep;
    logic        tx_tlast;
    axis_dest_t  tx_tdest;
    pack_count_t tx_tcount;

    // stimulus table
    axis_data_t row_data [ROWS];
    axis_keep_t row_keep [ROWS];
    logic       row_last [ROWS];
    axis_dest_t row_dest [ROWS];

    // beats still expected at the output, oldest first
    axis_data_t exp_data_q [$];
    axis_keep_t exp_keep_q [$];
    logic       exp_last_q [$];
    axis_dest_t exp_dest_q [$];
    int         exp_count_q [$];
    int         exp_accept_q [$];   // accept cycle, -1 when not timed

    int          pass_idx = 0;
    int          cycle_count = 0;
    logic [31:0] lcg_state = 32'haaca;

    tb_clock_gen i_clock_gen (
        .clk (aclk)
    );

    byte_pack i_byte_pack (
        .aclk      (aclk),
        .rst       (rst),
        .rx_tvalid (rx_tvalid),
        .rx_tready (rx_tready),
        .rx_tdata  (rx_tdata),
        .rx_tkeep  (rx_tkeep),
        .rx_tlast  (rx_tlast),
        .rx_tdest  (rx_tdest),
        .tx_tvalid (tx_tvalid),
        .tx_tready (tx_tready),
        .tx_tdata  (tx_tdata),
        .tx_tkeep  (tx_tkeep),
        .tx_tlast  (tx_tlast),
        .tx_tdest  (tx_tdest),
        .tx_tcount (tx_tcount)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // kept bytes in ascending order from lane 0, rest zero
    function automatic void pack_expected(input axis_data_t data, input axis_keep_t keep,
                                          output axis_data_t packed_data,
                                          output axis_keep_t packed_keep, output int count);
        count = 0;
        packed_data = '0;
        packed_keep = '0;
        for (int k = 0; k < `PACK_TDATA_BYTES; k++) begin
            if (keep[k]) begin
                packed_data[count] = data[k];
                packed_keep[count] = 1'b1;  // lowest count bits set
                count++;
            end
        end
    endfunction

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            stop_with_error($sformatf("MISMATCH at %0t: %s got %h expected %h",
                                      $time, name, got, exp));
        end
    endtask

    task automatic set_row(input int idx, input axis_data_t data, input axis_keep_t keep,
                           input logic last, input axis_dest_t dest);
        row_data[idx] = data;
        row_keep[idx] = keep;
        row_last[idx] = last;
        row_dest[idx] = dest;
    endtask

    task automatic load_table();
        set_row(0,  32'h44332211, 4'b1111, 1'b0, 2'd0);
        set_row(1,  32'ha4a3a2a1, 4'b1010, 1'b0, 2'd1);
        set_row(2,  32'hb4b3b2b1, 4'b0110, 1'b0, 2'd2);
        set_row(3,  32'hc4c3c2c1, 4'b1001, 1'b1, 2'd3);
        set_row(4,  32'hd4d3d2d1, 4'b0001, 1'b0, 2'd0);
        set_row(5,  32'he4e3e2e1, 4'b0000, 1'b0, 2'd1);    // dropped
        set_row(6,  32'hf4f3f2f1, 4'b0000, 1'b1, 2'd2);    // empty but closes packet
        set_row(7,  32'h14131211, 4'b1000, 1'b0, 2'd3);
        set_row(8,  32'h24232221, 4'b0100, 1'b0, 2'd0);
        set_row(9,  32'h34333231, 4'b0010, 1'b1, 2'd1);
        set_row(10, 32'h54535251, 4'b1100, 1'b0, 2'd2);
        set_row(11, 32'h64636261, 4'b0011, 1'b0, 2'd3);
        set_row(12, 32'h74737271, 4'b0101, 1'b0, 2'd0);
        set_row(13, 32'h84838281, 4'b1110, 1'b1, 2'd1);
        set_row(14, 32'h94939291, 4'b0111, 1'b0, 2'd2);
        set_row(15, 32'h5a4b3c2d, 4'b1011, 1'b0, 2'd3);
        set_row(16, 32'h1e2f3a4b, 4'b1101, 1'b0, 2'd0);
        set_row(17, 32'h99887766, 4'b0000, 1'b0, 2'd1);    // dropped
        set_row(18, 32'hdeadbeef, 4'b1111, 1'b1, 2'd2);
        set_row(19, 32'h0badf00d, 4'b0000, 1'b1, 2'd3);
    endtask

    // hold the row until the DUT takes it, then queue what should come out
    task automatic send_row(input int idx);
        axis_data_t exp_data;
        axis_keep_t exp_keep;
        int         exp_count;
        @(negedge aclk);
        rx_tvalid = 1'b1;
        rx_tdata  = row_data[idx];
        rx_tkeep  = row_keep[idx];
        rx_tlast  = row_last[idx];
        rx_tdest  = row_dest[idx];
        @(posedge aclk);
        while (!rx_tready) @(posedge aclk);
        if (row_keep[idx] != '0 || row_last[idx]) begin
            pack_expected(row_data[idx], row_keep[idx], exp_data, exp_keep, exp_count);
            exp_data_q.push_back(exp_data);
            exp_keep_q.push_back(exp_keep);
            exp_last_q.push_back(row_last[idx]);
            exp_dest_q.push_back(row_dest[idx]);
            exp_count_q.push_back(exp_count);
            exp_accept_q.push_back(pass_idx == 0 ? cycle_count : -1);
        end
    endtask

    always @(posedge aclk) cycle_count <= cycle_count + 1;

    // sink ready, random only in the throttled pass
    initial begin
        tx_tready = 1'b1;
        forever begin
            @(negedge aclk);
            if (pass_idx == 1) begin
                lcg_state = lcg_next(lcg_state);
                tx_tready = (lcg_state[17:16] != 2'b00);   // about 3 in 4
            end else begin
                tx_tready = 1'b1;
            end
        end
    end

    always @(posedge aclk) begin : output_monitor
        logic        held;
        axis_data_t  held_data;
        axis_keep_t  held_keep;
        logic        held_last;
        axis_dest_t  held_dest;
        pack_count_t held_count;
        int          accept;
        if (!rst) begin
            if (held) begin     // stalled last edge, nothing may move
                check_field("tx_tvalid", tx_tvalid, 1);
                check_field("tx_tdata", tx_tdata, held_data);
                check_field("tx_tkeep", tx_tkeep, held_keep);
                check_field("tx_tlast", tx_tlast, held_last);
                check_field("tx_tdest", tx_tdest, held_dest);
                check_field("tx_tcount", tx_tcount, held_count);
            end
            if (tx_tvalid && tx_tready) begin
                assert (exp_data_q.size() != 0) else begin
                    stop_with_error($sformatf("unexpected output beat at %0t", $time));
                end
                check_field("tx_tdata", tx_tdata, exp_data_q.pop_front());
                check_field("tx_tkeep", tx_tkeep, exp_keep_q.pop_front());
                check_field("tx_tlast", tx_tlast, exp_last_q.pop_front());
                check_field("tx_tdest", tx_tdest, exp_dest_q.pop_front());
                check_field("tx_tcount", tx_tcount, exp_count_q.pop_front());
                accept = exp_accept_q.pop_front();
                if (accept >= 0) begin
                    check_field("latency", cycle_count - accept, 2);   // edge N to N+2
                end
            end
            held       = tx_tvalid && !tx_tready;
            held_data  = tx_tdata;
            held_keep  = tx_tkeep;
            held_last  = tx_tlast;
            held_dest  = tx_tdest;
            held_count = tx_tcount;
        end else begin
            held = 1'b0;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge aclk);
        stop_with_error("watchdog expired before all beats came out");
    end

    initial begin
        rst       = 1'b1;
        rx_tvalid = 1'b0;
        rx_tdata  = '0;
        rx_tkeep  = '0;
        rx_tlast  = 1'b0;
        rx_tdest  = '0;
        load_table();
        repeat (RESET_CYCLES) begin
            @(posedge aclk);
            @(negedge aclk);
            check_field("tx_tvalid", tx_tvalid, 0);
            check_field("rx_tready", rx_tready, 1);
        end
        rst = 1'b0;
        @(posedge aclk);
        @(negedge aclk);
        check_field("tx_tvalid", tx_tvalid, 0);     // still idle after reset
        check_field("rx_tready", rx_tready, 1);
        for (int p = 0; p < PASSES; p++) begin
            pass_idx = p;
            for (int r = 0; r < ROWS; r++) begin
                send_row(r);
            end
            @(negedge aclk);
            rx_tvalid = 1'b0;
            while (exp_data_q.size() != 0) @(posedge aclk);    // drain before next pass
        end
        repeat (4) @(posedge aclk);     // room for a stray duplicate
        if (!tx_tvalid && exp_data_q.size() == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            stop_with_error("output still busy after the last expected beat");
        end
    end

endmodule

`default_nettype wire

// File: verif/tb_clock_gen.sv
// testbench clock source
`default_nettype none

module tb_clock_gen (
    output logic clk
);
    // period 4, rising edges at 2, 6, 10 ...
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

endmodule

`default_nettype wire
